//--- build.f
hw/serv_pkg.sv
hw/serial_if.sv
hw/serv_fetch.sv
hw/serv_decode.sv
hw/serv_regfile.sv
hw/serv_alu.sv
hw/serv_mem_if.sv
hw/serv_top.sv
sim/tb_bus_mem.sv
sim/tb_serv_top.sv

//--- hw/serial_if.sv
`timescale 1ns/10ps
`default_nettype none

interface serial_if;

   logic [4:0] cnt;      // bit index of the current phase
   logic       active;
   logic       imm_bit;
   logic       op_b_imm; // operand b from immediate
   logic       rs1_bit;
   logic       rs2_bit;
   logic       alu_bit;
   logic       mem_bit;

   modport ctrl (output cnt, active, imm_bit, op_b_imm);
   modport rf   (input cnt, active, alu_bit, mem_bit, output rs1_bit, rs2_bit);
   modport alu  (input cnt, active, imm_bit, op_b_imm, rs1_bit, rs2_bit, output alu_bit);
   modport mem  (input active, alu_bit, rs2_bit, output mem_bit);

endinterface

`default_nettype wire

//--- hw/serv_alu.sv
`timescale 1ns/10ps
`default_nettype none

module serv_alu (
   input  wire       clk,
   input  wire       i_arst_n,
   input  wire [2:0] i_alu_op,
   serial_if.alu     sif
);

   import serv_pkg::*;

   logic op_b;
   logic b_eff;
   logic is_sub;
   logic c_in;
   logic c_q;
   logic sum;

   assign op_b   = sif.op_b_imm ? sif.imm_bit : sif.rs2_bit;
   assign is_sub = i_alu_op == ALU_SUB;
   assign b_eff  = op_b ^ is_sub;                   // a + ~b + 1 for sub
   assign c_in   = sif.cnt == 5'd0 ? is_sub : c_q;
   assign sum    = sif.rs1_bit ^ b_eff ^ c_in;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         c_q <= 1'b0;
      else if (sif.active)
         c_q <= (sif.rs1_bit & b_eff) | (c_in & (sif.rs1_bit ^ b_eff));
   end

   always_comb begin
      case (i_alu_op)
         ALU_XOR:    sif.alu_bit = sif.rs1_bit ^ op_b;
         ALU_OR:     sif.alu_bit = sif.rs1_bit | op_b;
         ALU_AND:    sif.alu_bit = sif.rs1_bit & op_b;
         ALU_PASS_B: sif.alu_bit = op_b;
         default:    sif.alu_bit = sum;
      endcase
   end

   // a phase always starts from bit 0, so the carry is seeded
   ap_start_lsb: assert property (@(posedge clk) disable iff (!i_arst_n)
      $rose(sif.active) |-> sif.cnt == 5'd0);

endmodule

`default_nettype wire

//--- hw/serv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module serv_decode (
   input  wire               clk,
   input  wire               i_arst_n,
   input  serv_pkg::instr_t  i_instr,
   input  wire               i_instr_valid,
   input  wire               i_mem_done,
   output logic              o_retire,
   output logic [4:0]        o_rs1_addr,
   output logic [4:0]        o_rs2_addr,
   output logic [4:0]        o_rd_addr,
   output logic              o_rd_en,
   output logic              o_rd_sel,
   output logic [2:0]        o_alu_op,
   output logic              o_mem_start,
   output logic              o_mem_we,
   serial_if.ctrl            sif
);

   import serv_pkg::*;

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_EXEC = 2'd1;
   localparam logic [1:0] S_MEMW = 2'd2;
   localparam logic [1:0] S_LDWB = 2'd3;

   logic [1:0]  state;
   logic [4:0]  cnt_q;
   logic        st_ret_q; // sw retires one cycle after mem_done
   logic        is_op, is_addi, is_lui, is_load, is_store, is_mem, is_sub;
   logic        last;
   logic [2:0]  f3;
   logic [31:0] imm_word;

   assign f3       = i_instr.r.funct3;
   assign is_sub   = i_instr.r.funct7 == F7_SUB;
   assign is_op    = i_instr.r.opcode == OPC_OP &&
                     ((i_instr.r.funct7 == 7'd0 &&
                       f3 inside {F3_ADD_SUB, F3_XOR, F3_OR, F3_AND}) ||
                      (is_sub && f3 == F3_ADD_SUB));
   assign is_addi  = i_instr.r.opcode == OPC_OP_IMM && f3 == F3_ADD_SUB;
   assign is_lui   = i_instr.r.opcode == OPC_LUI;
   assign is_load  = i_instr.r.opcode == OPC_LOAD && f3 == F3_WORD;
   assign is_store = i_instr.r.opcode == OPC_STORE && f3 == F3_WORD;
   assign is_mem   = is_load | is_store;
   assign last     = cnt_q == 5'd31;

   always_comb begin
      if (is_lui)
         imm_word = {i_instr.u.imm, 12'd0};
      else if (is_store)
         imm_word = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
      else
         imm_word = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
   end

   always_comb begin
      o_alu_op = ALU_ADD; // addi, lw, sw address
      if (is_lui)
         o_alu_op = ALU_PASS_B;
      else if (is_op) begin
         case (f3)
            F3_XOR:  o_alu_op = ALU_XOR;
            F3_OR:   o_alu_op = ALU_OR;
            F3_AND:  o_alu_op = ALU_AND;
            default: o_alu_op = is_sub ? ALU_SUB : ALU_ADD;
         endcase
      end
   end

   assign sif.cnt      = cnt_q;
   assign sif.active   = state == S_EXEC || state == S_LDWB;
   assign sif.imm_bit  = imm_word[cnt_q];
   assign sif.op_b_imm = !is_op;

   assign o_rs1_addr  = i_instr.r.rs1;
   assign o_rs2_addr  = i_instr.r.rs2;
   assign o_rd_addr   = i_instr.r.rd;
   assign o_rd_en     = (state == S_EXEC && (is_op | is_addi | is_lui)) || state == S_LDWB;
   assign o_rd_sel    = state == S_LDWB ? RD_SEL_MEM : RD_SEL_ALU;
   assign o_mem_start = state == S_EXEC && last && is_mem;
   assign o_mem_we    = is_store;
   assign o_retire    = (state == S_EXEC && last && !is_mem) ||
                        (state == S_LDWB && last) || st_ret_q;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state    <= S_IDLE;
         cnt_q    <= 5'd0;
         st_ret_q <= 1'b0;
      end else begin
         st_ret_q <= state == S_MEMW && i_mem_done && !is_load;
         if (sif.active)
            cnt_q <= cnt_q + 5'd1; // wraps to 0 after bit 31
         case (state)
            S_IDLE: if (i_instr_valid) state <= S_EXEC;
            S_EXEC: if (last) state <= is_mem ? S_MEMW : S_IDLE;
            S_MEMW: if (i_mem_done) state <= is_load ? S_LDWB : S_IDLE;
            default: if (last) state <= S_IDLE;
         endcase
      end
   end

   ap_valid_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_instr_valid |-> state == S_IDLE);
   ap_done_memw: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_mem_done |-> state == S_MEMW);

endmodule

`default_nettype wire

//--- hw/serv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module serv_fetch #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  wire               clk,
   input  wire               i_arst_n,
   input  wire [31:0]        i_ibus_rdt,
   input  wire               i_ibus_ack,
   input  wire               i_retire,
   output logic [31:0]       o_ibus_adr,
   output logic              o_ibus_cyc,
   output serv_pkg::instr_t  o_instr,
   output logic              o_instr_valid
);

   logic [31:0] pc;
   logic        start_q; // first fetch after reset

   assign o_ibus_adr = pc;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc            <= RESET_PC;
         start_q       <= 1'b1;
         o_ibus_cyc    <= 1'b0;
         o_instr_valid <= 1'b0;
      end else begin
         start_q       <= 1'b0;
         o_instr_valid <= o_ibus_cyc & i_ibus_ack;
         if (i_retire)
            pc <= pc + 32'd4;
         if (o_ibus_cyc & i_ibus_ack)
            o_ibus_cyc <= 1'b0;
         else if (start_q | i_retire)
            o_ibus_cyc <= 1'b1;
      end
   end

   // instruction word held until the next ack
   always_ff @(posedge clk) begin
      if (o_ibus_cyc & i_ibus_ack)
         o_instr <= i_ibus_rdt;
   end

   ap_ibus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc && $stable(o_ibus_adr));

endmodule

`default_nettype wire

//--- hw/serv_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

module serv_mem_if (
   input  wire         clk,
   input  wire         i_arst_n,
   input  wire         i_start,
   input  wire         i_we,
   input  wire  [31:0] i_dbus_rdt,
   input  wire         i_dbus_ack,
   output logic        o_mem_done,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic [3:0]  o_dbus_sel,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc,
   serial_if.mem       sif
);

   logic [31:0] adr_q;
   logic [31:0] dat_q; // store data in, load data out

   assign o_dbus_adr  = {adr_q[31:2], 2'b00};
   assign o_dbus_dat  = dat_q;
   assign o_dbus_sel  = 4'b1111; // word access only
   assign sif.mem_bit = dat_q[0];

   always_ff @(posedge clk) begin
      if (sif.active) begin
         adr_q <= {sif.alu_bit, adr_q[31:1]};
         dat_q <= {sif.rs2_bit, dat_q[31:1]};
      end else if (o_dbus_cyc && i_dbus_ack && !o_dbus_we) begin
         dat_q <= i_dbus_rdt;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_dbus_cyc <= 1'b0;
         o_dbus_we  <= 1'b0;
         o_mem_done <= 1'b0;
      end else begin
         o_mem_done <= o_dbus_cyc & i_dbus_ack;
         if (o_dbus_cyc & i_dbus_ack) begin
            o_dbus_cyc <= 1'b0;
            o_dbus_we  <= 1'b0;
         end else if (i_start) begin
            o_dbus_cyc <= 1'b1;
            o_dbus_we  <= i_we;
         end
      end
   end

   ap_dbus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_dbus_cyc && !i_dbus_ack |=> o_dbus_cyc && $stable(o_dbus_adr) && $stable(o_dbus_dat));
   // start comes with the last bit of the address phase
   ap_start_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_start |-> !o_dbus_cyc && sif.active);

endmodule

`default_nettype wire

//--- hw/serv_pkg.sv
`default_nettype none

package serv_pkg;

   // opcodes of the supported subset
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_WORD    = 3'b010; // lw / sw

   localparam logic [6:0] F7_SUB = 7'b0100000;

   localparam logic [2:0] ALU_ADD    = 3'd0;
   localparam logic [2:0] ALU_SUB    = 3'd1;
   localparam logic [2:0] ALU_XOR    = 3'd2;
   localparam logic [2:0] ALU_OR     = 3'd3;
   localparam logic [2:0] ALU_AND    = 3'd4;
   localparam logic [2:0] ALU_PASS_B = 3'd5; // lui

   localparam logic RD_SEL_ALU = 1'b0;
   localparam logic RD_SEL_MEM = 1'b1;

   // one instruction word, four decode views
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm_hi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_lo;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic [19:0] imm;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
   } instr_t;

endpackage

`default_nettype wire

//--- hw/serv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module serv_regfile (
   input  wire       clk,
   input  wire       i_arst_n,
   input  wire [4:0] i_rs1_addr,
   input  wire [4:0] i_rs2_addr,
   input  wire [4:0] i_rd_addr,
   input  wire       i_rd_en,
   input  wire       i_rd_sel,
   serial_if.rf      sif
);

   import serv_pkg::*;

   logic [31:0] regs [32];
   logic        wr_bit;
   logic        wr_en;

   assign wr_bit = i_rd_sel == RD_SEL_MEM ? sif.mem_bit : sif.alu_bit;
   assign wr_en  = sif.active && i_rd_en && i_rd_addr != 5'd0; // x0 stays zero

   // bit cnt of rs is read before the same bit of rd is overwritten
   assign sif.rs1_bit = sif.active & regs[i_rs1_addr][sif.cnt];
   assign sif.rs2_bit = sif.active & regs[i_rs2_addr][sif.cnt];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= 32'd0;
         end
      end else if (wr_en) begin
         regs[i_rd_addr][sif.cnt] <= wr_bit;
      end
   end

   ap_wr_active: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rd_en |-> sif.active);

   // every phase runs the full 32 bits
   ap_full_phase: assert property (@(posedge clk) disable iff (!i_arst_n)
      $fell(sif.active) |-> $past(sif.cnt) == 5'd31);

endmodule

`default_nettype wire

//--- hw/serv_top.sv
`timescale 1ns/10ps
`default_nettype none

module serv_top #(
   parameter logic [31:0] RESET_PC = 32'd0
) (
   input  wire         clk,
   input  wire         i_arst_n,
   input  wire  [31:0] i_ibus_rdt,
   input  wire         i_ibus_ack,
   input  wire  [31:0] i_dbus_rdt,
   input  wire         i_dbus_ack,
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   output logic [31:0] o_dbus_adr,
   output logic [31:0] o_dbus_dat,
   output logic [3:0]  o_dbus_sel,
   output logic        o_dbus_we,
   output logic        o_dbus_cyc
);

   import serv_pkg::*;

   instr_t     instr;
   logic       instr_valid;
   logic       retire;
   logic [4:0] rs1_addr;
   logic [4:0] rs2_addr;
   logic [4:0] rd_addr;
   logic       rd_en;
   logic       rd_sel;
   logic [2:0] alu_op;
   logic       mem_start;
   logic       mem_we;
   logic       mem_done;

   serial_if sif ();

   serv_fetch #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .i_retire      (retire),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_instr       (instr),
      .o_instr_valid (instr_valid)
   );

   serv_decode u_decode (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_instr       (instr),
      .i_instr_valid (instr_valid),
      .i_mem_done    (mem_done),
      .o_retire      (retire),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_en       (rd_en),
      .o_rd_sel      (rd_sel),
      .o_alu_op      (alu_op),
      .o_mem_start   (mem_start),
      .o_mem_we      (mem_we),
      .sif           (sif)
   );

   serv_regfile u_regfile (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_rd_sel   (rd_sel),
      .sif        (sif)
   );

   serv_alu u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_alu_op (alu_op),
      .sif      (sif)
   );

   serv_mem_if u_mem_if (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_start    (mem_start),
      .i_we       (mem_we),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_mem_done (mem_done),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .sif        (sif)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the serv_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_serv_top -f build.f -o vsim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   echo "verilator build failed, see $BUILD_LOG"
   exit 1
fi

./obj_dir/vsim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$SIM_LOG"; then
   exit 1
fi
if grep -q "Test OK" "$SIM_LOG"; then
   exit 0
fi
echo "no result line found in $SIM_LOG"
exit 1

//--- sim/tb_bus_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bus_mem (
   input  wire         clk,
   input  wire         i_arst_n,
   input  wire  [31:0] i_ibus_adr,
   input  wire         i_ibus_cyc,
   output logic [31:0] o_ibus_rdt = 32'd0,
   output logic        o_ibus_ack = 1'b0,
   input  wire  [31:0] i_dbus_adr,
   input  wire  [31:0] i_dbus_dat,
   input  wire         i_dbus_we,
   input  wire         i_dbus_cyc,
   output logic [31:0] o_dbus_rdt = 32'd0,
   output logic        o_dbus_ack = 1'b0
);

   logic [31:0] mem [1024]; // program and data, 4 KiB
   logic [1:0]  i_wait = 2'd0;
   logic [1:0]  d_wait = 2'd0;
   logic [31:0] st_adr_q [$]; // every store seen on the data bus
   logic [31:0] st_dat_q [$];

   // unsupported opcode in every word, so a stray fetch is a no-op
   task automatic clear_mem();
      for (int i = 0; i < 1024; i++) begin
         mem[i] = {i[24:0], 7'h7f};
      end
   endtask

   task automatic write_word(input int idx, input logic [31:0] w);
      mem[idx] = w;
   endtask

   always @(posedge clk) begin
      if (!i_arst_n) begin
         o_ibus_ack <= 1'b0;
         o_dbus_ack <= 1'b0;
      end else begin
         if (o_ibus_ack) begin
            o_ibus_ack <= 1'b0;
            i_wait     <= 2'($urandom % 4);
         end else if (i_ibus_cyc) begin
            if (i_wait == 2'd0) begin
               o_ibus_ack <= 1'b1;
               o_ibus_rdt <= mem[i_ibus_adr[11:2]];
            end else
               i_wait <= i_wait - 2'd1;
         end
         if (o_dbus_ack) begin
            o_dbus_ack <= 1'b0;
            d_wait     <= 2'($urandom % 4);
         end else if (i_dbus_cyc) begin
            if (d_wait == 2'd0) begin
               o_dbus_ack <= 1'b1;
               o_dbus_rdt <= mem[i_dbus_adr[11:2]];
               if (i_dbus_we) begin
                  mem[i_dbus_adr[11:2]] <= i_dbus_dat;
                  st_adr_q.push_back(i_dbus_adr);
                  st_dat_q.push_back(i_dbus_dat);
               end
            end else
               d_wait <= d_wait - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- sim/tb_serv_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_serv_top;

   import serv_pkg::*;

   localparam int N_TESTS = 6;

   logic        clk;
   logic        arst_n;
   logic [31:0] ibus_adr, ibus_rdt, dbus_adr, dbus_dat, dbus_rdt;
   logic        ibus_cyc, ibus_ack, dbus_cyc, dbus_ack, dbus_we;
   logic [3:0]  dbus_sel;

   logic [31:0] ref_regs [32];
   logic [31:0] dmem_ref [int]; // expected data memory by address
   logic [31:0] exp_adr_q [$];
   logic [31:0] exp_dat_q [$];
   int          exp_tst_q [$];
   int          exp_cnt [N_TESTS];
   int          seen_cnt [N_TESTS];
   int          test_err [N_TESTS];
   string       test_name [N_TESTS];
   int          pc_idx = 0;
   int          cur_test = 0;
   int          total_exp = 0;
   int          checked = 0;
   int          bus_err = 0;
   int          n_pass;
   logic [31:0] slot = 32'h400; // next free store address
   logic [31:0] exp_pc = 32'd0;
   logic        cyc_q = 1'b0;
   logic        build_done = 1'b0;
   logic [31:0] got_adr, got_dat;
   int          got_tst;

   serv_top #(.RESET_PC(32'd0)) dut_i (
      .clk(clk), .i_arst_n(arst_n),
      .i_ibus_rdt(ibus_rdt), .i_ibus_ack(ibus_ack),
      .i_dbus_rdt(dbus_rdt), .i_dbus_ack(dbus_ack),
      .o_ibus_adr(ibus_adr), .o_ibus_cyc(ibus_cyc),
      .o_dbus_adr(dbus_adr), .o_dbus_dat(dbus_dat), .o_dbus_sel(dbus_sel),
      .o_dbus_we(dbus_we), .o_dbus_cyc(dbus_cyc)
   );

   tb_bus_mem mem_i (
      .clk(clk), .i_arst_n(arst_n),
      .i_ibus_adr(ibus_adr), .i_ibus_cyc(ibus_cyc),
      .o_ibus_rdt(ibus_rdt), .o_ibus_ack(ibus_ack),
      .i_dbus_adr(dbus_adr), .i_dbus_dat(dbus_dat), .i_dbus_we(dbus_we),
      .i_dbus_cyc(dbus_cyc), .o_dbus_rdt(dbus_rdt), .o_dbus_ack(dbus_ack)
   );

   function automatic instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
      instr_t w;
      w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
      return w;
   endfunction

   function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
      instr_t w;
      w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
      return w;
   endfunction

   function automatic instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
      instr_t w;
      w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: 5'd0, funct3: F3_WORD,
              imm_lo: imm[4:0], opcode: OPC_STORE};
      return w;
   endfunction

   function automatic instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
      instr_t w;
      w.u = '{imm: imm, rd: rd, opcode: OPC_LUI};
      return w;
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // reference result of a register-register instruction
   function automatic logic [31:0] op_ref(input logic [2:0] f3, input logic [6:0] f7,
                                          input logic [31:0] a, input logic [31:0] b);
      case (f3)
         F3_XOR:  return a ^ b;
         F3_OR:   return a | b;
         F3_AND:  return a & b;
         default: return f7 == F7_SUB ? a - b : a + b;
      endcase
   endfunction

   task automatic emit(input instr_t w);
      mem_i.write_word(pc_idx, w);
      pc_idx++;
   endtask

   task automatic wr_reg(input logic [4:0] rd, input logic [31:0] v);
      if (rd != 5'd0)
         ref_regs[rd] = v; // x0 stays zero
   endtask

   task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
      logic [19:0] hi;
      logic [11:0] lo;
      lo = value[11:0];
      hi = value[31:12] + {19'd0, value[11]}; // addi sign-extends lo
      emit(enc_u(hi, rd));
      wr_reg(rd, {hi, 12'd0});
      emit(enc_i(lo, rd, F3_ADD_SUB, rd, OPC_OP_IMM));
      wr_reg(rd, ref_regs[rd] + sext12(lo));
   endtask

   task automatic do_op(input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
      emit(enc_r(f7, rs2, rs1, f3, rd));
      wr_reg(rd, op_ref(f3, f7, ref_regs[rs1], ref_regs[rs2]));
   endtask

   task automatic do_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
      emit(enc_i(imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM));
      wr_reg(rd, ref_regs[rs1] + sext12(imm));
   endtask

   task automatic store_reg(input logic [4:0] rs, output logic [31:0] adr);
      adr = slot;
      emit(enc_s(slot[11:0], rs));
      exp_adr_q.push_back(slot);
      exp_dat_q.push_back(ref_regs[rs]);
      exp_tst_q.push_back(cur_test);
      dmem_ref[int'(slot)] = ref_regs[rs];
      exp_cnt[cur_test]++;
      slot = slot + 32'd4;
   endtask

   task automatic build_program();
      logic [31:0] a;
      logic [4:0]  rd;
      mem_i.clear_mem();
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = 32'd0;
      end
      cur_test = 0; // reset and fetch order
      load_reg(5'd1, $urandom);
      store_reg(5'd1, a);
      cur_test = 1; // arithmetic
      load_reg(5'd1, $urandom);
      load_reg(5'd2, $urandom);
      load_reg(5'd3, 32'hffff_ffff);
      load_reg(5'd4, 32'd1);
      do_op(F3_ADD_SUB, 7'd0, 5'd5, 5'd1, 5'd2);
      do_op(F3_ADD_SUB, F7_SUB, 5'd6, 5'd1, 5'd2);
      do_op(F3_ADD_SUB, 7'd0, 5'd7, 5'd3, 5'd4);   // wraps to zero
      do_op(F3_ADD_SUB, F7_SUB, 5'd8, 5'd0, 5'd4); // wraps below zero
      do_addi(5'd9, 5'd1, 12'($urandom));
      do_addi(5'd10, 5'd3, 12'd1);
      do_op(F3_ADD_SUB, 7'd0, 5'd1, 5'd1, 5'd2);   // rd same as rs1
      for (int r = 5; r <= 10; r++) begin
         store_reg(5'(r), a);
      end
      store_reg(5'd1, a);
      cur_test = 2; // logic and lui
      load_reg(5'd12, $urandom);
      load_reg(5'd13, $urandom);
      do_op(F3_AND, 7'd0, 5'd14, 5'd12, 5'd13);
      do_op(F3_OR, 7'd0, 5'd15, 5'd12, 5'd13);
      do_op(F3_XOR, 7'd0, 5'd16, 5'd12, 5'd13);
      emit(enc_u(20'($urandom), 5'd17));
      wr_reg(5'd17, {mem_i.mem[pc_idx - 1][31:12], 12'd0});
      for (int r = 14; r <= 17; r++) begin
         store_reg(5'(r), a);
      end
      cur_test = 3; // memory round trip
      load_reg(5'd18, $urandom);
      store_reg(5'd18, a);
      emit(enc_i(a[11:0], 5'd0, F3_WORD, 5'd19, OPC_LOAD));
      wr_reg(5'd19, dmem_ref[int'(a)]);
      store_reg(5'd19, a);
      cur_test = 4; // x0 and unsupported words
      load_reg(5'd0, $urandom);
      do_op(F3_ADD_SUB, 7'd0, 5'd0, 5'd1, 5'd2);
      do_addi(5'd0, 5'd1, 12'h7ff);
      store_reg(5'd0, a);
      emit(enc_r(7'd0, 5'd2, 5'd1, 3'b001, 5'd1)); // sll, not in the subset
      emit(32'hffff_ffff);
      store_reg(5'd1, a);
      store_reg(5'd31, a);
      cur_test = 5; // random ops under random ack latency
      repeat (6) begin
         rd = 5'(20 + $urandom % 8);
         load_reg(5'd28, $urandom);
         load_reg(5'd29, $urandom);
         case ($urandom % 5)
            0: do_op(F3_ADD_SUB, 7'd0, rd, 5'd28, 5'd29);
            1: do_op(F3_ADD_SUB, F7_SUB, rd, 5'd28, 5'd29);
            2: do_op(F3_XOR, 7'd0, rd, 5'd28, 5'd29);
            3: do_op(F3_OR, 7'd0, rd, 5'd28, 5'd29);
            default: do_op(F3_AND, 7'd0, rd, 5'd28, 5'd29);
         endcase
         store_reg(rd, a);
      end
      total_exp = exp_adr_q.size();
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // each new instruction fetch is the previous address plus 4
   always @(posedge clk) begin
      cyc_q <= ibus_cyc;
      if (arst_n && ibus_cyc && !cyc_q) begin
         assert (ibus_adr == exp_pc) else begin
            $display("[ERROR] %0t: fetch address %h, expected %h", $time, ibus_adr, exp_pc);
            bus_err++;
         end
         exp_pc <= exp_pc + 32'd4;
      end
   end

   // compare every store against the reference model
   always @(posedge clk) begin
      if (mem_i.st_adr_q.size() > 0) begin
         got_adr = mem_i.st_adr_q.pop_front();
         got_dat = mem_i.st_dat_q.pop_front();
         if (exp_adr_q.size() == 0) begin
            $display("unexpected store to %h at %0t", got_adr, $time);
            bus_err++;
         end else begin
            got_tst = exp_tst_q.pop_front();
            assert (got_adr == exp_adr_q[0] && got_dat == exp_dat_q[0]) else begin
               $display("[ERROR] %0t: %s store %h to %h, expected %h to %h", $time,
                        test_name[got_tst], got_dat, got_adr, exp_dat_q[0], exp_adr_q[0]);
               test_err[got_tst]++;
            end
            void'(exp_adr_q.pop_front());
            void'(exp_dat_q.pop_front());
            seen_cnt[got_tst]++;
            checked++;
            if (seen_cnt[got_tst] == exp_cnt[got_tst])
               $display("test %0d %s: %s, %0d stores", got_tst, test_name[got_tst],
                        test_err[got_tst] == 0 ? "pass" : "fail", seen_cnt[got_tst]);
         end
      end
   end

   ap_reset_idle: assert property (@(posedge clk) !arst_n |-> !ibus_cyc && !dbus_cyc)
      else begin
         $display("a bus cycle was active during reset at %0t", $time);
         bus_err++;
      end
   ap_ibus_hold: assert property (@(posedge clk) disable iff (!arst_n)
      ibus_cyc && !ibus_ack |=> ibus_cyc && $stable(ibus_adr))
      else begin
         $display("instruction bus dropped cyc or moved the address before ack at %0t", $time);
         bus_err++;
      end
   ap_dbus_hold: assert property (@(posedge clk) disable iff (!arst_n)
      dbus_cyc && !dbus_ack |=> dbus_cyc && $stable(dbus_adr) && $stable(dbus_dat)
                                && $stable(dbus_we))
      else begin
         $display("data bus changed its request before ack at %0t", $time);
         bus_err++;
      end
   ap_dbus_sel: assert property (@(posedge clk) disable iff (!arst_n)
      dbus_cyc |-> dbus_sel == 4'hf)
      else begin
         $display("data bus select was not all ones at %0t", $time);
         bus_err++;
      end
   ap_we_cyc: assert property (@(posedge clk) disable iff (!arst_n) dbus_we |-> dbus_cyc)
      else begin
         $display("write enable high outside a data bus cycle at %0t", $time);
         bus_err++;
      end

   initial begin
      void'($urandom(32'h1d11));
      arst_n = 1'b0;
      test_name = '{"reset_fetch", "arith", "logic_lui", "mem_roundtrip", "reg_zero",
                    "backpressure"};
      for (int t = 0; t < N_TESTS; t++) begin
         exp_cnt[t]  = 0;
         seen_cnt[t] = 0;
         test_err[t] = 0;
      end
      build_program();
      build_done = 1'b1;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      wait (checked == total_exp);
      repeat (4) @(posedge clk);
      n_pass = 0;
      for (int t = 0; t < N_TESTS; t++) begin
         if (test_err[t] == 0)
            n_pass++;
      end
      $display("tests passed %0d, failed %0d, bus errors %0d", n_pass, N_TESTS - n_pass,
               bus_err);
      if (n_pass == N_TESTS && bus_err == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // watchdog, 120 cycles per instruction is well above the worst case
   initial begin
      wait (build_done);
      #(pc_idx * 120 * 4);
      $display("run timed out, only %0d of %0d stores seen", checked, total_exp);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire
